// ==== filelist.f ====
sme_pkg.sv
sme_buffer_if.sv
sme_char_store.sv
sme_match_ctrl.sv
sme.sv
sme_asserts.sv
tb_sme.sv

// ==== Bender.yml ====
package:
  name: sme

sources:
  - sme_pkg.sv
  - sme_buffer_if.sv
  - sme_char_store.sv
  - sme_match_ctrl.sv
  - sme.sv
  - target: test
    files:
      - sme_asserts.sv
      - tb_sme.sv

// ==== tb_sme.sv ====
module tb_sme;
    timeunit 1ns;
    timeprecision 1ps;

    import sme_pkg::*;

    // Worst-case scan latency plus some slack
    localparam int wait_limit = str_max * (pat_max + 1) + 4 + 40;

    logic     clk;
    logic     reset;
    char_t    chardata;
    logic     isstring;
    logic     ispattern;
    logic     valid;
    logic     match;
    str_idx_t match_index;

    // Copy of what the DUT holds, used by the model
    char_t    str_buf [str_max];
    char_t    pat_buf [pat_max];
    int       str_n;
    int       pat_n;

    integer   seed = 32'h5c4d_d284;
    int       pass_count;
    int       fail_count;

    sme sme_i
    (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    initial
        clk = 1'b0;

    always #4 clk = ~clk;

    // ========================================
    // Buffers and reference model
    // ========================================
    function automatic void set_case(input string s, input string p);
        str_n = s.len();
        pat_n = p.len();
        for (int i = 0; i < str_max; i++)
            str_buf[i] = (i < str_n) ? char_t'(s[i]) : '0;
        for (int i = 0; i < pat_max; i++)
            pat_buf[i] = (i < pat_n) ? char_t'(p[i]) : '0;
    endfunction

    // Lowest frame wins; index is where the first body character sits
    function automatic void predict(output logic hit, output int idx);
        int   sp;
        int   first;
        int   body_lo;
        int   body_hi;
        logic ok;
        logic anchor_start;
        logic anchor_end;
        hit = 1'b0;
        idx = 0;
        if (pat_n == 0)
            return;
        anchor_start = (pat_buf[0] == char_hat);
        anchor_end   = (pat_buf[pat_n-1] == char_dollar) && !(anchor_start && pat_n == 1);
        body_lo      = anchor_start ? 1 : 0;
        body_hi      = anchor_end ? pat_n - 1 : pat_n;
        for (int f = 0; f <= str_n && !hit; f++)
        begin
            sp = f;
            ok = 1'b1;
            // At index 0 the anchor holds without eating a space
            if (anchor_start && f != 0)
            begin
                if (f < str_n && str_buf[f] == char_space)
                    sp = f + 1;
                else
                    ok = 1'b0;
            end
            first = sp;
            for (int i = body_lo; i < body_hi; i++)
            begin
                if (ok && sp < str_n &&
                    (pat_buf[i] == char_point || pat_buf[i] == str_buf[sp]))
                    sp++;
                else
                    ok = 1'b0;
            end
            if (ok && anchor_end)
                ok = (sp == str_n) || (sp < str_n && str_buf[sp] == char_space);
            if (ok)
            begin
                hit = 1'b1;
                idx = first;
            end
        end
    endfunction

    // ========================================
    // Stimulus
    // ========================================
    task automatic run_test(input string name, input bit load_str, input bit load_pat);
        logic     exp_hit;
        int       exp_idx;
        int       cycles;
        int       errs_before;
        bit       seen;
        bit       bad;
        logic     got_match;
        str_idx_t got_index;
        predict(exp_hit, exp_idx);
        errs_before = sme_i.sme_asserts_i.error_count;
        bad         = 1'b0;
        got_match   = 1'b0;
        got_index   = '0;
        // Bursts run back to back so the scan starts only once
        if (load_str)
        begin
            for (int i = 0; i < str_n; i++)
            begin
                chardata = str_buf[i];
                isstring = 1'b1;
                @(posedge clk);
                #1;
            end
        end
        isstring = 1'b0;
        if (load_pat)
        begin
            for (int i = 0; i < pat_n; i++)
            begin
                chardata  = pat_buf[i];
                ispattern = 1'b1;
                @(posedge clk);
                #1;
            end
        end
        ispattern = 1'b0;
        chardata  = '0;
        cycles    = 0;
        seen      = 1'b0;
        while (!seen && cycles < wait_limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
            seen = valid;
        end
        if (!seen)
        begin
            $display("Test %s: no valid pulse within %0d cycles", name, wait_limit);
            bad = 1'b1;
        end
        else
        begin
            got_match = match;
            got_index = match_index;
            if (got_match !== exp_hit)
            begin
                $display("** Error %s: match expected %0b actual %0b",
                         name, exp_hit, got_match);
                bad = 1'b1;
            end
            if (exp_hit && got_index !== str_idx_t'(exp_idx))
            begin
                $display("** Error %s: match_index expected %0d actual %0d",
                         name, exp_idx, got_index);
                bad = 1'b1;
            end
        end
        // Step past the done cycle back into loading
        @(posedge clk);
        #1;
        if (sme_i.sme_asserts_i.error_count != errs_before)
        begin
            $display("Test %s: a bound assertion fired during the test", name);
            bad = 1'b1;
        end
        if (bad)
            fail_count++;
        else
            pass_count++;
        $display("%s  %s  match=%0b index=%0d", bad ? "FAIL" : "pass", name,
                 got_match, got_index);
    endtask

    task automatic make_random_pair();
        string alpha_str;
        string alpha_pat;
        int    body;
        int    k;
        alpha_str = "ab c";
        alpha_pat = "ab.";
        str_n     = 4 + $unsigned($random(seed)) % 29;
        for (int i = 0; i < str_max; i++)
            str_buf[i] = (i < str_n) ? char_t'(alpha_str[$unsigned($random(seed)) % 4]) : '0;
        for (int i = 0; i < pat_max; i++)
            pat_buf[i] = '0;
        k = 0;
        if ($unsigned($random(seed)) % 3 == 0)
        begin
            pat_buf[k] = char_hat;
            k++;
        end
        body = 1 + $unsigned($random(seed)) % 3;
        for (int i = 0; i < body; i++)
        begin
            pat_buf[k] = char_t'(alpha_pat[$unsigned($random(seed)) % 3]);
            k++;
        end
        if ($unsigned($random(seed)) % 3 == 0)
        begin
            pat_buf[k] = char_dollar;
            k++;
        end
        pat_n = k;
    endtask

    initial
    begin
        chardata   = '0;
        isstring   = 1'b0;
        ispattern  = 1'b0;
        reset      = 1'b1;
        pass_count = 0;
        fail_count = 0;
        str_n      = 0;
        pat_n      = 0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        // Idle cycles with no load must give no valid
        repeat (3) @(posedge clk);
        #1;

        set_case("xyz abcab", "cab");
        run_test("lit_hit", 1, 1);
        set_case("xyz abcab", "abd");
        run_test("lit_miss", 1, 1);
        set_case("ab cd", "b.c");
        run_test("dot_space", 1, 1);
        set_case("qrst", "r.t");
        run_test("dot_letter", 1, 1);
        set_case("abc def", "^abc");
        run_test("hat_index0", 1, 1);
        set_case("xabc def", "^def");
        run_test("hat_after_space", 1, 1);
        set_case("xabc", "^abc");
        run_test("hat_midword", 1, 1);
        set_case("abc def", "def$");
        run_test("dollar_end", 1, 1);
        set_case("abc def", "abc$");
        run_test("dollar_space", 1, 1);
        set_case("abcd", "abc$");
        run_test("dollar_midword", 1, 1);

        // Pattern reload keeps the string, string reload drops the old tail
        set_case("alpha beta", "beta");
        run_test("reload_first", 1, 1);
        set_case("alpha beta", "ha b");
        run_test("reload_pattern", 0, 1);
        set_case("alpha", "ha b");
        run_test("reload_string", 1, 0);

        for (int t = 0; t < 40; t++)
        begin
            make_random_pair();
            run_test($sformatf("rand_%0d", t), 1, 1);
        end

        $display("Tests passed %0d, failed %0d, assertion errors %0d",
                 pass_count, fail_count, sme_i.sme_asserts_i.error_count);
        if (fail_count == 0 && sme_i.sme_asserts_i.error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== sme_asserts.sv ====
module sme_asserts
(
    input logic              clk,
    input logic              reset,
    input logic              isstring,
    input logic              ispattern,
    input logic              valid,
    input logic              match,
    input sme_pkg::str_idx_t match_index,
    input sme_pkg::str_len_t str_len
);
    timeunit 1ns;
    timeprecision 1ps;

    int   error_count = 0;
    // Some character has loaded since reset
    logic seen_load;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            seen_load <= 1'b0;
        else if (isstring || ispattern)
            seen_load <= 1'b1;
    end

    // ========================================
    // Result protocol
    // ========================================
    valid_pulse: assert property (@(posedge clk) disable iff (reset) valid |=> !valid)
    else
    begin
        $error("valid stayed high for more than one cycle");
        error_count++;
    end

    match_in_valid: assert property (@(posedge clk) disable iff (reset) match |-> valid)
    else
    begin
        $error("match high without valid");
        error_count++;
    end

    index_in_range: assert property (@(posedge clk) disable iff (reset)
                                     match |-> (match_index < str_len))
    else
    begin
        $error("match_index not below the string length");
        error_count++;
    end

    no_early_valid: assert property (@(posedge clk) disable iff (reset) valid |-> seen_load)
    else
    begin
        $error("valid after reset before any load");
        error_count++;
    end

endmodule

bind sme sme_asserts sme_asserts_i
(
    .clk         (clk),
    .reset       (reset),
    .isstring    (isstring),
    .ispattern   (ispattern),
    .valid       (valid),
    .match       (match),
    .match_index (match_index),
    .str_len     (char_buf.str_len)
);

// ==== sme.sv ====
module sme
(
    input  logic              clk,
    input  logic              reset,
    input  sme_pkg::char_t    chardata,
    input  logic              isstring,
    input  logic              ispattern,
    output logic              valid,
    output logic              match,
    output sme_pkg::str_idx_t match_index
);

    // ========================================
    // Storage to control link
    // ========================================
    sme_buffer_if char_buf ();

    // String and pattern buffers
    sme_char_store store_i
    (
        .clk       (clk),
        .reset     (reset),
        .chardata  (chardata),
        .isstring  (isstring),
        .ispattern (ispattern),
        .buf_if    (char_buf.store)
    );

    // Phase control, scan and result
    sme_match_ctrl ctrl_i
    (
        .clk         (clk),
        .reset       (reset),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .buf_if      (char_buf.ctrl),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

endmodule

// ==== sme_match_ctrl.sv ====
module sme_match_ctrl
(
    input  logic              clk,
    input  logic              reset,
    input  logic              isstring,
    input  logic              ispattern,
    sme_buffer_if.ctrl        buf_if,
    output logic              valid,
    output logic              match,
    output sme_pkg::str_idx_t match_index
);
    import sme_pkg::*;

    sme_phase_e  phase;
    sme_phase_e  phase_next;
    scan_mode_e  mode;
    char_class_e pat_class;

    pat_idx_t    pat_ptr;
    str_len_t    str_ptr;
    str_len_t    frame;
    str_len_t    frame_next;
    // String index of the first character after any '^'
    str_len_t    first_idx;

    logic        loaded;
    logic        match_q;

    logic        pat_last;
    logic        in_str;
    logic        str_is_space;
    logic        char_hit;
    logic        start_ok;
    logic        end_ok;
    logic        found;
    logic        miss;
    logic        frame_over;
    logic        scan_end;

    logic [$bits(str_len_t):0] frame_reach;
    logic [$bits(str_len_t):0] frame_limit;

    // ========================================
    // Character decode and compare
    // ========================================
    assign pat_last     = ({1'b0, pat_ptr} + pat_len_t'(1)) == buf_if.pat_len;
    assign in_str       = str_ptr < buf_if.str_len;
    assign str_is_space = in_str && (buf_if.str_char == char_space);

    // Anchors only count at the pattern edges
    always_comb
    begin
        if (pat_ptr == '0 && buf_if.pat_char == char_hat)
            pat_class = class_start;
        else if (pat_last && buf_if.pat_char == char_dollar)
            pat_class = class_end;
        else if (buf_if.pat_char == char_point)
            pat_class = class_any;
        else
            pat_class = class_literal;
    end

    assign char_hit = in_str &&
                      (pat_class == class_any || buf_if.str_char == buf_if.pat_char);
    assign start_ok = (str_ptr == '0) || str_is_space;
    assign end_ok   = (str_ptr == buf_if.str_len) || str_is_space;

    always_comb
    begin
        found = 1'b0;
        miss  = 1'b0;
        case (mode)
            mode_normal:
            begin
                // Anchor characters just switch the mode this cycle
                if (pat_class != class_start && pat_class != class_end)
                begin
                    found = char_hit && pat_last;
                    miss  = !char_hit;
                end
            end
            mode_word_start:
            begin
                found = start_ok && pat_last;
                miss  = !start_ok;
            end
            mode_word_end:
            begin
                found = end_ok;
                miss  = !end_ok;
            end
            default:
            begin
                miss = 1'b1;
            end
        endcase
    end

    // Two spare frames cover the anchors, which hold no literal
    assign frame_next  = frame + 1'b1;
    assign frame_reach = {1'b0, frame_next} + ($bits(frame_reach))'(buf_if.pat_len);
    assign frame_limit = {1'b0, buf_if.str_len} + ($bits(frame_limit))'(2);
    assign frame_over  = frame_reach > frame_limit;

    assign scan_end = found || (miss && frame_over) || (buf_if.pat_len == '0);

    // ========================================
    // Phase FSM
    // ========================================
    always_comb
    begin
        phase_next = phase;
        case (phase)
            phase_load:
            begin
                if (loaded && !isstring && !ispattern)
                    phase_next = phase_scan;
            end
            phase_scan:
            begin
                if (scan_end)
                    phase_next = phase_done;
            end
            default:
            begin
                phase_next = phase_load;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase  <= phase_load;
            loaded <= 1'b0;
        end
        else
        begin
            phase <= phase_next;
            if (phase == phase_done)
                loaded <= 1'b0;
            else if (phase == phase_load && (isstring || ispattern))
                loaded <= 1'b1;
        end
    end

    // ========================================
    // Scan mode FSM and pointers
    // ========================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            mode      <= mode_normal;
            pat_ptr   <= '0;
            str_ptr   <= '0;
            frame     <= '0;
            first_idx <= '0;
        end
        else if (phase == phase_done)
        begin
            mode      <= mode_normal;
            pat_ptr   <= '0;
            str_ptr   <= '0;
            frame     <= '0;
            first_idx <= '0;
        end
        else if (phase == phase_scan)
        begin
            if (miss)
            begin
                // Retry one position further on
                mode      <= mode_normal;
                pat_ptr   <= '0;
                str_ptr   <= frame_next;
                frame     <= frame_next;
                first_idx <= frame_next;
            end
            else
            begin
                case (mode)
                    mode_normal:
                    begin
                        if (pat_class == class_start)
                            mode <= mode_word_start;
                        else if (pat_class == class_end)
                            mode <= mode_word_end;
                        else
                        begin
                            pat_ptr <= pat_ptr + 1'b1;
                            str_ptr <= str_ptr + 1'b1;
                        end
                    end
                    mode_word_start:
                    begin
                        mode    <= mode_normal;
                        pat_ptr <= pat_ptr + 1'b1;
                        // Space before the word is consumed
                        if (str_ptr != '0)
                        begin
                            str_ptr   <= str_ptr + 1'b1;
                            first_idx <= str_ptr + 1'b1;
                        end
                    end
                    default:
                    begin
                        mode <= mode_normal;
                    end
                endcase
            end
        end
    end

    // ========================================
    // Result
    // ========================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            match_q     <= 1'b0;
            match_index <= '0;
        end
        else if (phase == phase_scan && found)
        begin
            match_q     <= 1'b1;
            match_index <= first_idx[$bits(str_idx_t)-1:0];
        end
        else if (phase == phase_done)
            match_q <= 1'b0;
    end

    assign valid = (phase == phase_done);
    // Flag is set entering done and cleared leaving it
    assign match = match_q;

    assign buf_if.loading  = (phase == phase_load);
    assign buf_if.str_addr = str_ptr[$bits(str_idx_t)-1:0];
    assign buf_if.pat_addr = pat_ptr;

endmodule

// ==== sme_char_store.sv ====
module sme_char_store
(
    input  logic           clk,
    input  logic           reset,
    input  sme_pkg::char_t chardata,
    input  logic           isstring,
    input  logic           ispattern,
    sme_buffer_if.store    buf_if
);
    import sme_pkg::*;

    char_t    str_mem [str_max];
    char_t    pat_mem [pat_max];

    str_len_t str_len;
    pat_len_t pat_len;

    // Next write starts a new burst
    logic     str_fresh;
    logic     pat_fresh;

    logic     str_wr;
    logic     pat_wr;
    logic     str_full;
    logic     pat_full;

    assign str_wr   = buf_if.loading && isstring;
    assign pat_wr   = buf_if.loading && ispattern;
    assign str_full = (str_len == str_len_t'(str_max));
    assign pat_full = (pat_len == pat_len_t'(pat_max));

    // ========================================
    // Length counters and burst flags
    // ========================================
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            str_len   <= '0;
            pat_len   <= '0;
            str_fresh <= 1'b1;
            pat_fresh <= 1'b1;
        end
        else if (!buf_if.loading)
        begin
            // Any result closes the current bursts
            str_fresh <= 1'b1;
            pat_fresh <= 1'b1;
        end
        else
        begin
            if (isstring)
            begin
                str_fresh <= 1'b0;
                if (str_fresh)
                    str_len <= str_len_t'(1);
                else if (!str_full)
                    str_len <= str_len + 1'b1;
            end
            if (ispattern)
            begin
                pat_fresh <= 1'b0;
                if (pat_fresh)
                    pat_len <= pat_len_t'(1);
                else if (!pat_full)
                    pat_len <= pat_len + 1'b1;
            end
        end
    end

    // ========================================
    // Register files
    // ========================================
    always_ff @(posedge clk)
    begin
        if (str_wr)
        begin
            if (str_fresh)
            begin
                // Old tail must not leak into the new string
                for (int i = 1; i < str_max; i++)
                    str_mem[i] <= '0;
                str_mem[0] <= chardata;
            end
            else if (!str_full)
                str_mem[str_len[$bits(str_idx_t)-1:0]] <= chardata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pat_wr)
        begin
            if (pat_fresh)
            begin
                for (int i = 1; i < pat_max; i++)
                    pat_mem[i] <= '0;
                pat_mem[0] <= chardata;
            end
            else if (!pat_full)
                pat_mem[pat_len[$bits(pat_idx_t)-1:0]] <= chardata;
        end
    end

    // Asynchronous reads
    assign buf_if.str_char = str_mem[buf_if.str_addr];
    assign buf_if.pat_char = pat_mem[buf_if.pat_addr];
    assign buf_if.str_len  = str_len;
    assign buf_if.pat_len  = pat_len;

endmodule

// ==== sme_buffer_if.sv ====
interface sme_buffer_if;
    import sme_pkg::*;

    // Read addresses from the match control
    str_idx_t str_addr;
    pat_idx_t pat_addr;

    // Characters at those addresses, same cycle
    char_t    str_char;
    char_t    pat_char;

    // Current buffer fill levels
    str_len_t str_len;
    pat_len_t pat_len;

    // High while the engine accepts new characters
    logic     loading;

    modport store
    (
        input  str_addr,
        input  pat_addr,
        input  loading,
        output str_char,
        output pat_char,
        output str_len,
        output pat_len
    );

    modport ctrl
    (
        output str_addr,
        output pat_addr,
        output loading,
        input  str_char,
        input  pat_char,
        input  str_len,
        input  pat_len
    );

endinterface

// ==== sme_pkg.sv ====
package sme_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int char_width = 8;
    localparam int str_max    = 32;
    localparam int pat_max    = 8;

    typedef logic [char_width-1:0]        char_t;
    typedef logic [$clog2(str_max)-1:0]   str_idx_t;
    typedef logic [$clog2(str_max):0]     str_len_t;
    typedef logic [$clog2(pat_max)-1:0]   pat_idx_t;
    typedef logic [$clog2(pat_max):0]     pat_len_t;

    // ========================================
    // Character codes
    // ========================================
    localparam char_t char_hat    = 8'h5e;
    localparam char_t char_dollar = 8'h24;
    localparam char_t char_point  = 8'h2e;
    localparam char_t char_space  = 8'h20;

    // ========================================
    // State and class encodings
    // ========================================
    typedef enum logic [1:0] {
        phase_load,
        phase_scan,
        phase_done
    } sme_phase_e;

    typedef enum logic [1:0] {
        mode_normal,
        mode_word_start,
        mode_word_end
    } scan_mode_e;

    typedef enum logic [1:0] {
        class_literal,
        class_any,
        class_start,
        class_end
    } char_class_e;

endpackage
